// ==== source/cpe_pkg.sv ====
////////////////////////////////////////
// Shared definitions for the register-access path
// Address is 19 bits, top 3 bits select the unit
// Only unit codes 0 and 1 are mapped, others are dropped
// Plain strobes, no handshake and no back-pressure
////////////////////////////////////////

`default_nettype none

package cpe_pkg;

    ////////////////////////////////////////
    // Widths and unit codes
    ////////////////////////////////////////
    localparam int ADDR_W = 19;
    localparam int DATA_W = 32;
    localparam int UNIT_W = 3;

    localparam logic [UNIT_W-1:0] UNIT_ISC  = 3'd0;
    localparam logic [UNIT_W-1:0] UNIT_GATE = 3'd1;

    // Gate control table geometry
    localparam int GATE_ENTRIES = 16;
    localparam int GATE_IDX_W   = 4;

    ////////////////////////////////////////
    // Address views
    ////////////////////////////////////////

    // Fixed register view, used when the fixed flag is set
    typedef struct packed {
        logic [UNIT_W-1:0]        unit;
        logic [ADDR_W-UNIT_W-1:0] reg_idx;
    } cpe_fix_addr_t;

    // Table view, used when the fixed flag is clear
    typedef struct packed {
        logic [UNIT_W-1:0]        unit;
        logic [ADDR_W-UNIT_W-1:0] entry;
    } cpe_tbl_addr_t;

    typedef union packed {
        cpe_fix_addr_t fix;
        cpe_tbl_addr_t tbl;
    } cpe_addr_u;

    ////////////////////////////////////////
    // Command and response words
    ////////////////////////////////////////

    // One host command, write wins if both strobes are high
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic              fixed;
        cpe_addr_u         addr;
        logic [DATA_W-1:0] wdata;
    } cpe_cmd_t;

    // One read answer, all zero when idle
    typedef struct packed {
        logic              valid;
        logic              fixed;
        cpe_addr_u         addr;
        logic [DATA_W-1:0] rdata;
    } cpe_rsp_t;

endpackage

`default_nettype wire

// ==== source/cmd_parse.sv ====
////////////////////////////////////////
// Command parser
// One command per cycle, one cycle of latency
// Strobes reach only the unit named by the
// address unit field, unknown units are dropped
// Both strobes are passed as given, the units
// apply write precedence themselves
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cmd_parse (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  cpe_pkg::cpe_cmd_t i_cmd,
    output cpe_pkg::cpe_cmd_t o_isc_cmd,
    output cpe_pkg::cpe_cmd_t o_gate_cmd
);

    logic [cpe_pkg::UNIT_W-1:0] unit_sel;
    logic                       sel_isc;
    logic                       sel_gate;

    ////////////////////////////////////////
    // Unit decode
    ////////////////////////////////////////

    // Unit field sits in the same place in both address views
    assign unit_sel = i_cmd.addr.fix.unit;
    assign sel_isc  = (unit_sel == cpe_pkg::UNIT_ISC);
    assign sel_gate = (unit_sel == cpe_pkg::UNIT_GATE);

    ////////////////////////////////////////
    // Per-unit command registers
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_isc_cmd <= '0;
        end
        else begin
            // Payload follows the input, strobes only on a match
            o_isc_cmd.fixed <= i_cmd.fixed;
            o_isc_cmd.addr  <= i_cmd.addr;
            o_isc_cmd.wdata <= i_cmd.wdata;
            o_isc_cmd.wr    <= i_cmd.wr & sel_isc;
            o_isc_cmd.rd    <= i_cmd.rd & sel_isc;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_gate_cmd <= '0;
        end
        else begin
            o_gate_cmd.fixed <= i_cmd.fixed;
            o_gate_cmd.addr  <= i_cmd.addr;
            o_gate_cmd.wdata <= i_cmd.wdata;
            o_gate_cmd.wr    <= i_cmd.wr & sel_gate;
            o_gate_cmd.rd    <= i_cmd.rd & sel_gate;
        end
    end

endmodule

`default_nettype wire

// ==== source/isc_regs.sv ====
////////////////////////////////////////
// Ingress statistics unit
// Only fixed register 0 is readable, it holds
// a 32-bit packet count that wraps
// Writes are ignored and give no response
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module isc_regs (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  cpe_pkg::cpe_cmd_t i_cmd,
    input  wire               i_pkt,
    output cpe_pkg::cpe_rsp_t o_rsp
);

    logic [cpe_pkg::DATA_W-1:0] pkt_cnt;
    logic                       rd_hit;

    ////////////////////////////////////////
    // Packet counter
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pkt_cnt <= '0;
        end
        else if (i_pkt) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Read response
    ////////////////////////////////////////

    // A write in the same cycle masks the read
    assign rd_hit = i_cmd.rd && !i_cmd.wr && i_cmd.fixed &&
                    (i_cmd.addr.fix.reg_idx == '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp <= '0;
        end
        else if (rd_hit) begin
            // Count as it stood before this edge
            o_rsp.valid <= 1'b1;
            o_rsp.fixed <= i_cmd.fixed;
            o_rsp.addr  <= i_cmd.addr;
            o_rsp.rdata <= pkt_cnt;
        end
        else begin
            o_rsp <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/gate_cfg_regs.sv ====
////////////////////////////////////////
// Gate configuration unit
// Fixed register 0 is the cycle time
// Table entries 0 to 15 are the gate list
// Other locations ignore writes and stay silent on reads
// A read returns the value held before the edge
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module gate_cfg_regs (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  cpe_pkg::cpe_cmd_t i_cmd,
    output cpe_pkg::cpe_rsp_t o_rsp
);

    logic [cpe_pkg::DATA_W-1:0] cycle_time;
    logic [cpe_pkg::DATA_W-1:0] gate_tbl [cpe_pkg::GATE_ENTRIES];

    logic                           hit_cyc;
    logic                           hit_tbl;
    logic [cpe_pkg::GATE_IDX_W-1:0] tbl_idx;
    logic                           do_wr;
    logic                           do_rd;

    ////////////////////////////////////////
    // Location decode
    ////////////////////////////////////////

    assign hit_cyc = i_cmd.fixed && (i_cmd.addr.fix.reg_idx == '0);
    assign hit_tbl = !i_cmd.fixed && (i_cmd.addr.tbl.entry < cpe_pkg::GATE_ENTRIES);
    assign tbl_idx = i_cmd.addr.tbl.entry[cpe_pkg::GATE_IDX_W-1:0];

    // Write has precedence over read
    assign do_wr = i_cmd.wr;
    assign do_rd = i_cmd.rd && !i_cmd.wr;

    ////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cycle_time <= '0;
            for (int i = 0; i < cpe_pkg::GATE_ENTRIES; i++) begin
                gate_tbl[i] <= '0;
            end
        end
        else if (do_wr) begin
            if (hit_cyc) begin
                cycle_time <= i_cmd.wdata;
            end
            else if (hit_tbl) begin
                gate_tbl[tbl_idx] <= i_cmd.wdata;
            end
        end
    end

    ////////////////////////////////////////
    // Read response
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp <= '0;
        end
        else if (do_rd && (hit_cyc || hit_tbl)) begin
            o_rsp.valid <= 1'b1;
            o_rsp.fixed <= i_cmd.fixed;
            o_rsp.addr  <= i_cmd.addr;
            o_rsp.rdata <= hit_cyc ? cycle_time : gate_tbl[tbl_idx];
        end
        else begin
            o_rsp <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/rsp_merge.sv ====
////////////////////////////////////////
// Response merger
// At most one unit answers per cycle since the
// parser routes each command to one unit only
// Output is one register stage, zero when idle
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rsp_merge (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  cpe_pkg::cpe_rsp_t i_isc_rsp,
    input  cpe_pkg::cpe_rsp_t i_gate_rsp,
    output cpe_pkg::cpe_rsp_t o_rsp
);

    cpe_pkg::cpe_rsp_t rsp_sel;

    // Pick by valid bits, no address decode here
    always_comb begin
        if (i_isc_rsp.valid) begin
            rsp_sel = i_isc_rsp;
        end
        else if (i_gate_rsp.valid) begin
            rsp_sel = i_gate_rsp;
        end
        else begin
            rsp_sel = '0;
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp <= '0;
        end
        else begin
            o_rsp <= rsp_sel;
        end
    end

endmodule

`default_nettype wire

// ==== source/cpe_top.sv ====
////////////////////////////////////////
// Register-access top level
// Read to response latency is 3 cycles, fixed
// One command per cycle, no stall on responses
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cpe_top (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  cpe_pkg::cpe_cmd_t i_cmd,
    input  wire               i_pkt,
    output cpe_pkg::cpe_rsp_t o_rsp
);

    // Parser to units
    cpe_pkg::cpe_cmd_t isc_cmd;
    cpe_pkg::cpe_cmd_t gate_cmd;

    // Units to merger
    cpe_pkg::cpe_rsp_t isc_rsp;
    cpe_pkg::cpe_rsp_t gate_rsp;

    cmd_parse u_parse (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (i_cmd),
        .o_isc_cmd  (isc_cmd),
        .o_gate_cmd (gate_cmd)
    );

    isc_regs u_isc (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (isc_cmd),
        .i_pkt   (i_pkt),
        .o_rsp   (isc_rsp)
    );

    gate_cfg_regs u_gate (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (gate_cmd),
        .o_rsp   (gate_rsp)
    );

    rsp_merge u_merge (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_isc_rsp  (isc_rsp),
        .i_gate_rsp (gate_rsp),
        .o_rsp      (o_rsp)
    );

endmodule

`default_nettype wire

// ==== test/cpe_chk.sv ====
////////////////////////////////////////
// Bound checks for the register-access top
// Sampled on the rising clock edge
// Reads with a write beside them, or to unmapped
// locations, are not expected to answer
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cpe_chk (
    input wire               i_clk,
    input wire               i_rst_n,
    input cpe_pkg::cpe_cmd_t i_isc_cmd,
    input cpe_pkg::cpe_cmd_t i_gate_cmd,
    input cpe_pkg::cpe_rsp_t i_isc_rsp,
    input cpe_pkg::cpe_rsp_t i_gate_rsp,
    input cpe_pkg::cpe_rsp_t i_rsp
);

    logic isc_rd_live;
    logic gate_rd_live;

    // Count of failed assertions
    int fail_cnt = 0;

    // Parser reads that reach a mapped location
    assign isc_rd_live = i_isc_cmd.rd && !i_isc_cmd.wr && i_isc_cmd.fixed &&
                         (i_isc_cmd.addr.fix.reg_idx == 16'd0);
    assign gate_rd_live = i_gate_cmd.rd && !i_gate_cmd.wr &&
                          (i_gate_cmd.fixed ? (i_gate_cmd.addr.fix.reg_idx == 16'd0) :
                                              (i_gate_cmd.addr.tbl.entry < 16'd16));

    rd_one_unit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_isc_cmd.rd && i_gate_cmd.rd))
        else begin
            fail_cnt++;
            $error("Parser raised read strobes to both units");
        end

    rsp_one_unit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_isc_rsp.valid && i_gate_rsp.valid))
        else begin
            fail_cnt++;
            $error("Both unit responses valid in one cycle");
        end

    rsp_quiet_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_rsp.valid)
        else begin
            fail_cnt++;
            $error("Response valid while reset is asserted");
        end

    // Unit stage plus merger stage
    rd_answered: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (isc_rd_live || gate_rd_live) |-> ##2 i_rsp.valid)
        else begin
            fail_cnt++;
            $error("Mapped read got no response two cycles later");
        end

endmodule

bind cpe_top cpe_chk u_chk (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_isc_cmd  (isc_cmd),
    .i_gate_cmd (gate_cmd),
    .i_isc_rsp  (isc_rsp),
    .i_gate_rsp (gate_rsp),
    .i_rsp      (o_rsp)
);

`default_nettype wire

// ==== test/tb_cpe.sv ====
////////////////////////////////////////
// Testbench for the register-access top
// Random commands from a 16-bit Galois LFSR
// Commands driven at edge C answer after edge C+3
// Expected answers come from a model of the map
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_cpe;

    localparam int          RAND_CYCLES   = 600;
    localparam int          RST_TIMEOUT   = 20;
    localparam int          DRAIN_TIMEOUT = 20;
    localparam logic [15:0] LFSR_SEED     = 16'd62780;

    // Expected answer tagged with its arrival cycle
    typedef struct packed {
        logic [31:0]       cyc;
        cpe_pkg::cpe_rsp_t rsp;
    } exp_t;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_pkt;
    cpe_pkg::cpe_cmd_t i_cmd;
    cpe_pkg::cpe_rsp_t o_rsp;

    logic [15:0] lfsr;
    logic [31:0] cyc;
    int          errors;
    int          checks;
    exp_t        exp_q[$];

    // Model state
    logic [31:0] m_pkt_cnt;
    logic [31:0] m_cycle_time;
    logic [31:0] m_gate_tbl [16];

    cpe_top u_dut (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (i_cmd),
        .i_pkt   (i_pkt),
        .o_rsp   (o_rsp)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic cpe_pkg::cpe_cmd_t make_cmd(input logic wr, input logic rd,
                                                   input logic [2:0] unit, input logic fixed,
                                                   input logic [15:0] idx,
                                                   input logic [31:0] data);
        cpe_pkg::cpe_cmd_t c;
        c                  = '0;
        c.wr               = wr;
        c.rd               = rd;
        c.fixed            = fixed;
        c.addr.fix.unit    = unit;
        c.addr.fix.reg_idx = idx;
        c.wdata            = data;
        return c;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic model_step(input cpe_pkg::cpe_cmd_t c, input logic pkt);
        logic [2:0]  unit;
        logic [15:0] idx;
        logic        is_gate;
        logic        hit;
        exp_t        e;
        unit    = c.addr.fix.unit;
        idx     = c.addr.fix.reg_idx;
        is_gate = (unit == cpe_pkg::UNIT_GATE);
        hit     = 1'b0;
        e       = '0;
        // A read sees every packet up to its own issue cycle
        if (pkt) begin
            m_pkt_cnt = m_pkt_cnt + 32'd1;
        end
        if (c.wr) begin
            if (is_gate && c.fixed && idx == 16'd0) begin
                m_cycle_time = c.wdata;
            end
            else if (is_gate && !c.fixed && idx < 16'd16) begin
                m_gate_tbl[idx[3:0]] = c.wdata;
            end
        end
        else if (c.rd) begin
            if (unit == cpe_pkg::UNIT_ISC && c.fixed && idx == 16'd0) begin
                hit         = 1'b1;
                e.rsp.rdata = m_pkt_cnt;
            end
            else if (is_gate && c.fixed && idx == 16'd0) begin
                hit         = 1'b1;
                e.rsp.rdata = m_cycle_time;
            end
            else if (is_gate && !c.fixed && idx < 16'd16) begin
                hit         = 1'b1;
                e.rsp.rdata = m_gate_tbl[idx[3:0]];
            end
        end
        if (hit) begin
            e.cyc       = cyc + 32'd3;
            e.rsp.valid = 1'b1;
            e.rsp.fixed = c.fixed;
            e.rsp.addr  = c.addr;
            exp_q.push_back(e);
        end
    endtask

    ////////////////////////////////////////
    // Per-cycle drive and check
    ////////////////////////////////////////

    task automatic check_output();
        exp_t e;
        checks++;
        if (exp_q.size() > 0 && exp_q[0].cyc == cyc) begin
            e = exp_q.pop_front();
            assert (o_rsp.valid === 1'b1) else begin
                errors++;
                $display("Read response due at cycle %0d did not appear", cyc);
            end
            if (o_rsp.valid === 1'b1) begin
                assert (o_rsp.fixed === e.rsp.fixed) else begin
                    errors++;
                    $display("FAILED o_rsp.fixed: expected %h, got %h", e.rsp.fixed, o_rsp.fixed);
                end
                assert (o_rsp.addr === e.rsp.addr) else begin
                    errors++;
                    $display("FAILED o_rsp.addr: expected %h, got %h", e.rsp.addr, o_rsp.addr);
                end
                assert (o_rsp.rdata === e.rsp.rdata) else begin
                    errors++;
                    $display("FAILED o_rsp.rdata: expected %h, got %h", e.rsp.rdata, o_rsp.rdata);
                end
            end
        end
        else begin
            assert (o_rsp.valid === 1'b0) else begin
                errors++;
                $display("Unexpected response at cycle %0d for address %h", cyc, o_rsp.addr);
            end
            if (o_rsp.valid === 1'b0) begin
                assert (o_rsp === '0) else begin
                    errors++;
                    $display("FAILED o_rsp: expected %h, got %h", {$bits(o_rsp){1'b0}}, o_rsp);
                end
            end
        end
    endtask

    task automatic run_cycle(input cpe_pkg::cpe_cmd_t c, input logic pkt);
        @(posedge i_clk);
        cyc   = cyc + 32'd1;
        i_cmd <= c;
        i_pkt <= pkt;
        model_step(c, pkt);
        @(negedge i_clk);
        check_output();
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge i_clk);
        while (!(i_rst_n === 1'b1 && o_rsp === '0) && n < RST_TIMEOUT) begin
            @(negedge i_clk);
            n++;
        end
        assert (i_rst_n === 1'b1 && o_rsp === '0) else begin
            errors++;
            $display("Reset release with an idle response port not seen in time");
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        cpe_pkg::cpe_cmd_t idle;
        logic [31:0]       v;
        logic              pkt;
        logic [2:0]        kind;
        logic [2:0]        unit;
        logic              fixed;
        logic [15:0]       idx;
        int                k;
        int                chk_errors;
        i_rst_n      = 1'b0;
        i_cmd        = '0;
        i_pkt        = 1'b0;
        lfsr         = LFSR_SEED;
        cyc          = '0;
        errors       = 0;
        checks       = 0;
        m_pkt_cnt    = '0;
        m_cycle_time = '0;
        for (k = 0; k < 16; k++) begin
            m_gate_tbl[k] = '0;
        end
        idle = make_cmd(1'b0, 1'b0, 3'd0, 1'b0, 16'd0, 32'd0);

        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        wait_reset_release();

        // Statistics right after reset, then with packets
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_ISC, 1'b1, 16'd0, 32'd0), 1'b0);
        run_cycle(idle, 1'b1);
        run_cycle(idle, 1'b1);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_ISC, 1'b1, 16'd0, 32'd0), 1'b1);
        run_cycle(make_cmd(1'b1, 1'b0, cpe_pkg::UNIT_ISC, 1'b1, 16'd0, 32'h1234), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_ISC, 1'b0, 16'd0, 32'd0), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_ISC, 1'b1, 16'd1, 32'd0), 1'b0);
        // Gate table and cycle time
        run_cycle(make_cmd(1'b1, 1'b0, cpe_pkg::UNIT_GATE, 1'b0, 16'd5, 32'hA5A50005), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b0, 16'd5, 32'd0), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b0, 16'd6, 32'd0), 1'b0);
        run_cycle(make_cmd(1'b1, 1'b0, cpe_pkg::UNIT_GATE, 1'b1, 16'd0, 32'h0001E848), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b1, 16'd0, 32'd0), 1'b0);
        run_cycle(make_cmd(1'b1, 1'b0, cpe_pkg::UNIT_GATE, 1'b1, 16'd1, 32'hDEAD0001), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b1, 16'd1, 32'd0), 1'b0);
        run_cycle(make_cmd(1'b1, 1'b0, cpe_pkg::UNIT_GATE, 1'b0, 16'd16, 32'hDEAD0010), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b0, 16'd16, 32'd0), 1'b0);
        // Both strobes act as a write
        run_cycle(make_cmd(1'b1, 1'b1, cpe_pkg::UNIT_GATE, 1'b0, 16'd7, 32'h77770007), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b0, 16'd7, 32'd0), 1'b0);
        // Unmapped unit codes
        run_cycle(make_cmd(1'b0, 1'b1, 3'd2, 1'b1, 16'd0, 32'd0), 1'b0);
        run_cycle(make_cmd(1'b0, 1'b1, 3'd3, 1'b0, 16'd0, 32'd0), 1'b0);
        // Back-to-back reads
        for (k = 0; k < 4; k++) begin
            run_cycle(make_cmd(1'b0, 1'b1, cpe_pkg::UNIT_GATE, 1'b0, 16'(k), 32'd0), 1'b0);
        end

        for (k = 0; k < RAND_CYCLES; k++) begin
            take_bits(1, v);
            pkt = v[0];
            take_bits(3, v);
            kind = v[2:0];
            take_bits(2, v);
            unit = {1'b0, v[1:0]};
            take_bits(1, v);
            fixed = v[0];
            take_bits(5, v);
            idx = 16'(v % 32'd18);
            take_bits(32, v);
            // Kinds 0-1 idle, 2-3 write, 4-6 read, 7 both strobes
            run_cycle(make_cmd(kind == 3'd2 || kind == 3'd3 || kind == 3'd7, kind >= 3'd4,
                               unit, fixed, idx, v), pkt);
        end

        k = 0;
        while (exp_q.size() > 0 && k < DRAIN_TIMEOUT) begin
            run_cycle(idle, 1'b0);
            k++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        repeat (4) run_cycle(idle, 1'b0);

        chk_errors = u_dut.u_chk.fail_cnt;
        $display("Checks run: %0d, errors: %0d, bound assertion errors: %0d",
                 checks, errors, chk_errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/cpe_pkg.sv
source/cmd_parse.sv
source/isc_regs.sv
source/gate_cfg_regs.sv
source/rsp_merge.sv
source/cpe_top.sv
test/cpe_chk.sv
test/tb_cpe.sv

// ==== Makefile ====
# Verilator build and run for the register-access subsystem

VERILATOR  ?= verilator
TOP        ?= tb_cpe
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only if the pass line appears in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
